//--- common/videoCapturePkg.sv
package videoCapturePkg;

    // Beam counter and register widths
    localparam int CounterWidth = 12;
    localparam int ConfigDataWidth = 12;

    localparam int ColorWidth = 8;
    localparam int PixelWidth = 3 * ColorWidth;

    typedef enum logic [2:0] {
        HStart,
        HEnd,
        VStart,
        VEnd,
        GapStart,
        GapEnd,
        TriggerOffset,
        Mode
    } ConfigAddr;

    typedef enum logic [1:0] {
        Idle,
        WaitLine,
        Stream
    } ReaderState;

    // Interlaced skips the rows between gapStart and gapEnd
    typedef enum logic {
        Progressive,
        Interlaced
    } CaptureMode;

endpackage

//--- verilog/captureConfig.sv
module captureConfig #(
    parameter int MaxLineLength = 64,
    localparam int LengthWidth = $clog2(MaxLineLength + 1)
) (
    input  logic                                        clock,
    input  logic                                        nreset,
    input  logic                                        regWrite,
    input  videoCapturePkg::ConfigAddr                  regAddr,
    input  logic [videoCapturePkg::ConfigDataWidth-1:0] regWrData,
    output logic [videoCapturePkg::CounterWidth-1:0]    hStart,
    output logic [videoCapturePkg::CounterWidth-1:0]    hEnd,
    output logic [videoCapturePkg::CounterWidth-1:0]    vStart,
    output logic [videoCapturePkg::CounterWidth-1:0]    vEnd,
    output logic [videoCapturePkg::CounterWidth-1:0]    gapStart,
    output logic [videoCapturePkg::CounterWidth-1:0]    gapEnd,
    output logic [videoCapturePkg::CounterWidth-1:0]    triggerOffset,
    output videoCapturePkg::CaptureMode                 mode,
    output logic [LengthWidth-1:0]                      lineLength
);
    import videoCapturePkg::*;

    logic [CounterWidth-1:0] span;
    logic hStartSet;
    logic hEndSet;

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            hStart <= '0;
            hEnd <= '0;
            vStart <= '0;
            vEnd <= '0;
            gapStart <= '0;
            gapEnd <= '0;
            triggerOffset <= '0;
            mode <= Progressive;
            hStartSet <= 1'b0;
            hEndSet <= 1'b0;
        end else if (regWrite) begin
            case (regAddr)
                HStart: begin
                    hStart <= regWrData;
                    hStartSet <= 1'b1;
                end
                HEnd: begin
                    hEnd <= regWrData;
                    hEndSet <= 1'b1;
                end
                VStart: vStart <= regWrData;
                VEnd: vEnd <= regWrData;
                GapStart: gapStart <= regWrData;
                GapEnd: gapEnd <= regWrData;
                TriggerOffset: triggerOffset <= regWrData;
                Mode: mode <= CaptureMode'(regWrData[0]);
            endcase
        end
    end

    // Words per line, limited to one ring slot
    assign span = (hEnd > hStart) ? hEnd - hStart : '0;
    assign lineLength = (span > CounterWidth'(MaxLineLength)) ?
        LengthWidth'(MaxLineLength) : LengthWidth'(span);

    hWindowOrdered: assert property (@(posedge clock) disable iff (!nreset)
        hStartSet && hEndSet |-> hEnd >= hStart);

endmodule

//--- capture/videoCapture.sv
module videoCapture #(
    parameter int RingLines = 4,
    parameter int MaxLineLength = 64,
    localparam int AddrWidth = $clog2(RingLines * MaxLineLength),
    localparam int SlotWidth = (RingLines > 1) ? $clog2(RingLines) : 1,
    localparam int CreditWidth = $clog2(RingLines + 1)
) (
    input  logic                                     clock,
    input  logic                                     nreset,
    input  logic [videoCapturePkg::ColorWidth-1:0]   red,
    input  logic [videoCapturePkg::ColorWidth-1:0]   green,
    input  logic [videoCapturePkg::ColorWidth-1:0]   blue,
    input  logic [videoCapturePkg::CounterWidth-1:0] counterX,
    input  logic [videoCapturePkg::CounterWidth-1:0] counterY,
    input  logic [videoCapturePkg::CounterWidth-1:0] hStart,
    input  logic [videoCapturePkg::CounterWidth-1:0] hEnd,
    input  logic [videoCapturePkg::CounterWidth-1:0] vStart,
    input  logic [videoCapturePkg::CounterWidth-1:0] vEnd,
    input  logic [videoCapturePkg::CounterWidth-1:0] gapStart,
    input  logic [videoCapturePkg::CounterWidth-1:0] gapEnd,
    input  logic [videoCapturePkg::CounterWidth-1:0] triggerOffset,
    input  videoCapturePkg::CaptureMode              mode,
    input  logic                                     creditReturn,
    output logic                                     wrEnable,
    output logic [AddrWidth-1:0]                     wrAddr,
    output logic [videoCapturePkg::PixelWidth-1:0]   wrData,
    output logic                                     lineDone,
    output logic                                     startTrigger,
    output logic                                     overflow
);
    import videoCapturePkg::*;

    logic [CounterWidth-1:0] xOffset;
    logic newFrame;
    logic inGap;
    logic rowInWindow;
    logic pixelInWindow;
    logic lineStart;
    logic takeLine;
    logic writePixel;
    logic lineEnd;
    logic [CreditWidth-1:0] credits;
    logic [SlotWidth-1:0] slot;
    logic capturing;
    logic firstLine;

    assign xOffset = counterX - hStart;
    assign newFrame = (counterX == '0) && (counterY == '0);

    assign inGap = (mode == Interlaced) && (counterY >= gapStart) && (counterY < gapEnd);
    assign rowInWindow = (counterY >= vStart) && (counterY < vEnd) && !inGap;
    // Pixels past the slot size are not stored
    assign pixelInWindow = rowInWindow && (counterX >= hStart) && (counterX < hEnd)
        && (xOffset < CounterWidth'(MaxLineLength));

    assign lineStart = pixelInWindow && (counterX == hStart);
    assign takeLine = lineStart && (credits != '0);
    assign writePixel = pixelInWindow && (capturing || takeLine);
    assign lineEnd = capturing && !pixelInWindow;

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            wrEnable <= 1'b0;
            lineDone <= 1'b0;
            startTrigger <= 1'b0;
            overflow <= 1'b0;
            credits <= CreditWidth'(RingLines);
            slot <= '0;
            capturing <= 1'b0;
            firstLine <= 1'b0;
        end else begin
            wrEnable <= writePixel;
            lineDone <= lineEnd;
            startTrigger <= writePixel && (firstLine || newFrame) && (xOffset == triggerOffset);
            credits <= credits - CreditWidth'(takeLine) + CreditWidth'(creditReturn);

            if (lineStart && credits == '0) begin
                overflow <= 1'b1;
            end

            if (takeLine) begin
                capturing <= 1'b1;
            end else if (lineEnd) begin
                capturing <= 1'b0;
                slot <= (slot == SlotWidth'(RingLines - 1)) ? '0 : slot + 1'b1;
                firstLine <= 1'b0;
            end

            // Frame start wins over the end of the last line
            if (newFrame) begin
                firstLine <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (writePixel) begin
            wrAddr <= AddrWidth'(slot * MaxLineLength) + AddrWidth'(xOffset);
            wrData <= {red, green, blue};
        end
    end

    creditRange: assert property (@(posedge clock) disable iff (!nreset)
        credits <= CreditWidth'(RingLines));

    // The line being written holds one credit until the reader returns it
    writeNeedsCredit: assert property (@(posedge clock) disable iff (!nreset)
        wrEnable |-> credits < CreditWidth'(RingLines));

endmodule

//--- capture/lineRing.sv
module lineRing #(
    parameter int RingLines = 4,
    parameter int MaxLineLength = 64,
    localparam int Depth = RingLines * MaxLineLength,
    localparam int AddrWidth = $clog2(Depth)
) (
    input  logic                                   clock,
    input  logic                                   wrEnable,
    input  logic [AddrWidth-1:0]                   wrAddr,
    input  logic [videoCapturePkg::PixelWidth-1:0] wrData,
    input  logic                                   rdEnable,
    input  logic [AddrWidth-1:0]                   rdAddr,
    output logic [videoCapturePkg::PixelWidth-1:0] rdData
);
    import videoCapturePkg::*;

    // One slot of MaxLineLength words per line
    logic [PixelWidth-1:0] mem [Depth];

    always_ff @(posedge clock) begin
        if (wrEnable) begin
            mem[wrAddr] <= wrData;
        end
    end

    always_ff @(posedge clock) begin
        if (rdEnable) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

//--- verilog/lineReader.sv
module lineReader #(
    parameter int RingLines = 4,
    parameter int MaxLineLength = 64,
    localparam int AddrWidth = $clog2(RingLines * MaxLineLength),
    localparam int SlotWidth = (RingLines > 1) ? $clog2(RingLines) : 1,
    localparam int CountWidth = $clog2(RingLines + 1),
    localparam int LengthWidth = $clog2(MaxLineLength + 1)
) (
    input  logic                                   clock,
    input  logic                                   nreset,
    input  logic [LengthWidth-1:0]                 lineLength,
    input  logic                                   startTrigger,
    input  logic                                   lineDone,
    input  logic [videoCapturePkg::PixelWidth-1:0] rdData,
    input  logic                                   outReady,
    output logic                                   rdEnable,
    output logic [AddrWidth-1:0]                   rdAddr,
    output logic                                   outValid,
    output logic [videoCapturePkg::PixelWidth-1:0] outData,
    output logic                                   outLast,
    output logic                                   creditReturn
);
    import videoCapturePkg::*;

    ReaderState state;
    logic [CountWidth-1:0] readyLines;
    logic [SlotWidth-1:0] slot;
    logic [LengthWidth-1:0] rdCount;
    logic [LengthWidth-1:0] outCount;
    logic rdPending;
    logic [PixelWidth-1:0] holdBuf [2];
    logic headPtr;
    logic tailPtr;
    logic [1:0] held;
    logic [1:0] heldNext;
    logic pop;
    logic lineTaken;
    logic lineFinished;

    assign outValid = (held != 2'd0);
    assign outData = holdBuf[headPtr];
    assign outLast = outValid && (outCount == lineLength - 1'b1);
    assign pop = outValid && outReady;

    // Buffered words plus the read landing now, minus the beat leaving
    assign heldNext = held + 2'(rdPending) - 2'(pop);
    assign rdEnable = (state == Stream) && (rdCount < lineLength) && (heldNext < 2'd2);
    assign rdAddr = AddrWidth'(slot * MaxLineLength) + AddrWidth'(rdCount);

    assign lineTaken = (state == WaitLine) && (readyLines != '0);
    assign lineFinished = pop && outLast;

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            state <= Idle;
            readyLines <= '0;
            slot <= '0;
            rdCount <= '0;
            outCount <= '0;
            rdPending <= 1'b0;
            headPtr <= 1'b0;
            tailPtr <= 1'b0;
            held <= 2'd0;
            creditReturn <= 1'b0;
        end else begin
            rdPending <= rdEnable;
            creditReturn <= lineFinished;
            readyLines <= readyLines + CountWidth'(lineDone) - CountWidth'(lineTaken);
            held <= heldNext;

            if (rdPending) begin
                tailPtr <= ~tailPtr;
            end
            if (pop) begin
                headPtr <= ~headPtr;
                outCount <= outCount + 1'b1;
            end
            if (rdEnable) begin
                rdCount <= rdCount + 1'b1;
            end

            case (state)
                Idle: begin
                    if (startTrigger) begin
                        state <= WaitLine;
                    end
                end
                WaitLine: begin
                    if (lineTaken) begin
                        state <= Stream;
                        rdCount <= '0;
                        outCount <= '0;
                    end
                end
                Stream: begin
                    if (lineFinished) begin
                        state <= WaitLine;
                        slot <= (slot == SlotWidth'(RingLines - 1)) ? '0 : slot + 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rdPending) begin
            holdBuf[tailPtr] <= rdData;
        end
    end

    holdWhileStalled: assert property (@(posedge clock) disable iff (!nreset)
        outValid && !outReady |=> outValid && $stable(outData));

endmodule

//--- verilog/videoCaptureTop.sv
module videoCaptureTop #(
    parameter int RingLines = 4,
    parameter int MaxLineLength = 64,
    localparam int AddrWidth = $clog2(RingLines * MaxLineLength),
    localparam int LengthWidth = $clog2(MaxLineLength + 1)
) (
    input  logic                                        clock,
    input  logic                                        nreset,
    input  logic                                        regWrite,
    input  videoCapturePkg::ConfigAddr                  regAddr,
    input  logic [videoCapturePkg::ConfigDataWidth-1:0] regWrData,
    input  logic [videoCapturePkg::ColorWidth-1:0]      red,
    input  logic [videoCapturePkg::ColorWidth-1:0]      green,
    input  logic [videoCapturePkg::ColorWidth-1:0]      blue,
    input  logic [videoCapturePkg::CounterWidth-1:0]    counterX,
    input  logic [videoCapturePkg::CounterWidth-1:0]    counterY,
    input  logic                                        outReady,
    output logic                                        outValid,
    output logic [videoCapturePkg::PixelWidth-1:0]      outData,
    output logic                                        outLast,
    output logic                                        startTrigger,
    output logic                                        overflow
);
    import videoCapturePkg::*;

    logic [CounterWidth-1:0] hStart;
    logic [CounterWidth-1:0] hEnd;
    logic [CounterWidth-1:0] vStart;
    logic [CounterWidth-1:0] vEnd;
    logic [CounterWidth-1:0] gapStart;
    logic [CounterWidth-1:0] gapEnd;
    logic [CounterWidth-1:0] triggerOffset;
    CaptureMode mode;
    logic [LengthWidth-1:0] lineLength;
    logic wrEnable;
    logic [AddrWidth-1:0] wrAddr;
    logic [PixelWidth-1:0] wrData;
    logic rdEnable;
    logic [AddrWidth-1:0] rdAddr;
    logic [PixelWidth-1:0] rdData;
    logic lineDone;
    logic creditReturn;

    captureConfig #(
        .MaxLineLength(MaxLineLength)
    ) config0 (
        .clock(clock),
        .nreset(nreset),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWrData(regWrData),
        .hStart(hStart),
        .hEnd(hEnd),
        .vStart(vStart),
        .vEnd(vEnd),
        .gapStart(gapStart),
        .gapEnd(gapEnd),
        .triggerOffset(triggerOffset),
        .mode(mode),
        .lineLength(lineLength)
    );

    videoCapture #(
        .RingLines(RingLines),
        .MaxLineLength(MaxLineLength)
    ) capture0 (
        .clock(clock),
        .nreset(nreset),
        .red(red),
        .green(green),
        .blue(blue),
        .counterX(counterX),
        .counterY(counterY),
        .hStart(hStart),
        .hEnd(hEnd),
        .vStart(vStart),
        .vEnd(vEnd),
        .gapStart(gapStart),
        .gapEnd(gapEnd),
        .triggerOffset(triggerOffset),
        .mode(mode),
        .creditReturn(creditReturn),
        .wrEnable(wrEnable),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .lineDone(lineDone),
        .startTrigger(startTrigger),
        .overflow(overflow)
    );

    lineRing #(
        .RingLines(RingLines),
        .MaxLineLength(MaxLineLength)
    ) ring0 (
        .clock(clock),
        .wrEnable(wrEnable),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdEnable(rdEnable),
        .rdAddr(rdAddr),
        .rdData(rdData)
    );

    lineReader #(
        .RingLines(RingLines),
        .MaxLineLength(MaxLineLength)
    ) reader0 (
        .clock(clock),
        .nreset(nreset),
        .lineLength(lineLength),
        .startTrigger(startTrigger),
        .lineDone(lineDone),
        .rdData(rdData),
        .outReady(outReady),
        .rdEnable(rdEnable),
        .rdAddr(rdAddr),
        .outValid(outValid),
        .outData(outData),
        .outLast(outLast),
        .creditReturn(creditReturn)
    );

endmodule

//--- verif/videoCaptureTb.sv
module videoCaptureTb;
    timeunit 1ns;
    timeprecision 100ps;

    import videoCapturePkg::*;

    localparam int RingLines = 4;
    localparam int MaxLineLength = 64;
    localparam int FieldsPerCase = 12;
    localparam int DrainLimit = 50000;
    localparam int QuietCycles = 100;

    logic clock;
    logic nreset;
    logic regWrite;
    ConfigAddr regAddr;
    logic [ConfigDataWidth-1:0] regWrData;
    logic [ColorWidth-1:0] red;
    logic [ColorWidth-1:0] green;
    logic [ColorWidth-1:0] blue;
    logic [CounterWidth-1:0] counterX;
    logic [CounterWidth-1:0] counterY;
    logic outReady;
    logic outValid;
    logic [PixelWidth-1:0] outData;
    logic outLast;
    logic startTrigger;
    logic overflow;

    // Field order per case is hStart hEnd vStart vEnd gapStart gapEnd trigger mode
    // cols rows frames ready
    logic [15:0] vectors [256];
    int field [FieldsPerCase];
    int expRows [$];
    int expIndex;
    int beatIndex;
    int curRow;
    int lineLen;
    bit allowDrop;
    bit prevStalled;
    logic [PixelWidth-1:0] prevData;
    logic prevLast;
    int triggerCount;
    int errorCount;
    int timeoutCount;
    int beatCount;
    int lineCount;

    videoCaptureTop #(
        .RingLines(RingLines),
        .MaxLineLength(MaxLineLength)
    ) dut (
        .clock(clock),
        .nreset(nreset),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWrData(regWrData),
        .red(red),
        .green(green),
        .blue(blue),
        .counterX(counterX),
        .counterY(counterY),
        .outReady(outReady),
        .outValid(outValid),
        .outData(outData),
        .outLast(outLast),
        .startTrigger(startTrigger),
        .overflow(overflow)
    );

    always #4 clock = ~clock;

    function automatic bit rowExpected(int row);
        bit inGap;
        inGap = (field[7] != 0) && (row >= field[4]) && (row < field[5]);
        return (row >= field[2]) && (row < field[3]) && !inGap;
    endfunction

    function automatic int expectedLength();
        int span;
        span = (field[1] > field[0]) ? field[1] - field[0] : 0;
        return (span > MaxLineLength) ? MaxLineLength : span;
    endfunction

    function automatic logic [PixelWidth-1:0] expectedPixel(int x, int row);
        logic [7:0] r;
        logic [7:0] g;
        r = 8'(x);
        g = 8'(row);
        return {r, g, r ^ g};
    endfunction

    // One transferred beat against the expected line list
    task automatic takeBeat();
        int row;
        row = int'(outData[15:8]);
        if (beatIndex == 0) begin
            if (allowDrop) begin
                while (expIndex < expRows.size() && expRows[expIndex] != row) begin
                    expIndex++;
                end
            end
            if (expIndex >= expRows.size() || expRows[expIndex] != row) begin
                errorCount++;
                $display("ERROR %0t: unexpected line for row %0d", $time, row);
            end else begin
                expIndex++;
            end
            curRow = row;
        end
        if (outData !== expectedPixel(field[0] + beatIndex, curRow)) begin
            errorCount++;
            $display("ERROR %0t: row %0d pixel %0d is %h, expected %h", $time, curRow,
                beatIndex, outData, expectedPixel(field[0] + beatIndex, curRow));
        end
        if (outLast !== (beatIndex == lineLen - 1)) begin
            errorCount++;
            $display("ERROR %0t: outLast is %b at pixel %0d of row %0d", $time, outLast,
                beatIndex, curRow);
        end
        beatCount++;
        if (beatIndex == lineLen - 1) begin
            beatIndex = 0;
            lineCount++;
        end else begin
            beatIndex++;
        end
    endtask

    task automatic sampleOutputs();
        if (prevStalled) begin
            if (outValid !== 1'b1 || outData !== prevData || outLast !== prevLast) begin
                errorCount++;
                $display("ERROR %0t: output beat changed while stalled", $time);
            end
        end
        if (outValid === 1'b1 && triggerCount == 0) begin
            errorCount++;
            $display("ERROR %0t: outValid high before the first startTrigger", $time);
        end
        if (startTrigger === 1'b1) begin
            triggerCount++;
        end
        prevStalled = outValid && !outReady;
        prevData = outData;
        prevLast = outLast;
        if (outValid && outReady) begin
            takeBeat();
        end
    endtask

    task automatic tick();
        @(posedge clock);
        sampleOutputs();
    endtask

    task automatic resetDut();
        tick();
        nreset <= 1'b0;
        counterX <= 12'hfff;
        counterY <= 12'hfff;
        outReady <= 1'b0;
        repeat (2) tick();
        nreset <= 1'b1;
    endtask

    task automatic writeRegisters();
        for (int i = 0; i < 8; i++) begin
            tick();
            regWrite <= 1'b1;
            regAddr <= ConfigAddr'(i);
            regWrData <= ConfigDataWidth'(field[i]);
        end
        tick();
        regWrite <= 1'b0;
    endtask

    // Free running raster, frame after frame
    task automatic runRaster();
        int total;
        int stallCycles;
        int x;
        int y;
        total = field[8] * field[9] * field[10];
        stallCycles = total / 2;
        x = 0;
        y = 0;
        for (int cycle = 0; cycle < total; cycle++) begin
            tick();
            counterX <= 12'(x);
            counterY <= 12'(y);
            red <= 8'(x);
            green <= 8'(y);
            blue <= 8'(x) ^ 8'(y);
            case (field[11])
                0: outReady <= 1'b1;
                1: outReady <= 1'($urandom % 2);
                default: outReady <= (cycle >= stallCycles);
            endcase
            if (x == field[8] - 1) begin
                x = 0;
                y = (y == field[9] - 1) ? 0 : y + 1;
            end else begin
                x++;
            end
        end
        tick();
        counterX <= 12'hfff;
        counterY <= 12'hfff;
        outReady <= 1'b1;
    endtask

    task automatic drainOutput();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < QuietCycles && waited < DrainLimit) begin
            tick();
            quiet = outValid ? 0 : quiet + 1;
            waited++;
        end
        if (quiet < QuietCycles) begin
            timeoutCount++;
            $display("Timeout: the output stream did not go quiet after the raster ended");
        end
    endtask

    task automatic checkCase();
        if (beatIndex != 0) begin
            errorCount++;
            $display("ERROR %0t: last line stopped after %0d pixels", $time, beatIndex);
        end
        if (!allowDrop) begin
            if (expIndex != expRows.size()) begin
                errorCount++;
                $display("ERROR %0t: %0d of %0d lines seen", $time, expIndex, expRows.size());
            end
            if (overflow !== 1'b0) begin
                errorCount++;
                $display("ERROR %0t: overflow set with enough credits", $time);
            end
            if (triggerCount != field[10]) begin
                errorCount++;
                $display("ERROR %0t: %0d triggers for %0d frames", $time, triggerCount,
                    field[10]);
            end
        end else begin
            if (overflow !== 1'b1) begin
                errorCount++;
                $display("ERROR %0t: overflow not set after the long stall", $time);
            end
            if (triggerCount < 1 || triggerCount > field[10]) begin
                errorCount++;
                $display("ERROR %0t: %0d triggers for %0d frames", $time, triggerCount,
                    field[10]);
            end
        end
    endtask

    task automatic runCase(int index);
        expRows.delete();
        for (int f = 0; f < field[10]; f++) begin
            for (int r = 0; r < field[9]; r++) begin
                if (rowExpected(r)) begin
                    expRows.push_back(r);
                end
            end
        end
        expIndex = 0;
        beatIndex = 0;
        lineLen = expectedLength();
        allowDrop = (field[11] == 2);
        prevStalled = 1'b0;
        triggerCount = 0;
        $display("Case %0d: mode %0d, ready %0d, %0d lines of %0d pixels", index, field[7],
            field[11], expRows.size(), lineLen);
        resetDut();
        writeRegisters();
        runRaster();
        drainOutput();
        checkCase();
    endtask

    initial begin
        int caseCount;
        clock = 1'b0;
        nreset = 1'b0;
        regWrite = 1'b0;
        regAddr = HStart;
        regWrData = '0;
        red = '0;
        green = '0;
        blue = '0;
        counterX = 12'hfff;
        counterY = 12'hfff;
        outReady = 1'b0;
        errorCount = 0;
        timeoutCount = 0;
        beatCount = 0;
        lineCount = 0;
        void'($urandom(32'h26b7));
        for (int i = 0; i < 256; i++) begin
            vectors[i] = '0;
        end
        $readmemh("verif/videoCaptureVectors.txt", vectors);
        caseCount = int'(vectors[0]);
        if (caseCount == 0) begin
            errorCount++;
            $display("No test cases could be read from the vectors file");
        end
        for (int c = 0; c < caseCount; c++) begin
            for (int f = 0; f < FieldsPerCase; f++) begin
                field[f] = int'(vectors[1 + c * FieldsPerCase + f]);
            end
            runCase(c);
        end
        $display("Summary: %0d cases, %0d lines, %0d beats, %0d errors, %0d timeouts",
            caseCount, lineCount, beatCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/videoCaptureVectors.txt
// Case count, then one case per line, hex:
// hStart hEnd vStart vEnd gapStart gapEnd triggerOffset mode columns rows frames ready
// ready: 0 always high, 1 random, 2 held low for the first half of the raster
6
// Progressive window, ready always high
004 014 003 00c 000 000 005 0 030 010 3 0
// Interlaced, rows 5 to 8 skipped
002 012 002 00e 005 009 003 1 030 012 2 0
// Progressive window, random ready
004 014 003 00c 000 000 005 0 030 010 3 1
// Interlaced, random ready
003 01b 001 00f 004 00a 000 1 040 014 2 1
// Long stall runs out of credits
004 024 002 00e 000 000 002 0 040 010 4 2
// Line wider than a slot is clamped
000 050 001 004 000 000 00a 0 060 008 2 0

//--- videoCaptureTop.f
common/videoCapturePkg.sv
verilog/captureConfig.sv
capture/videoCapture.sv
capture/lineRing.sv
verilog/lineReader.sv
verilog/videoCaptureTop.sv
verif/videoCaptureTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

build=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module videoCaptureTb -Mdir "$build" -f videoCaptureTop.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build/VvideoCaptureTb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1
